//--- common/adc_pkg.sv
// shared constants of the integrating adc controller: widths, register map, switch codes
// imported by the serial register bank, the run-up sequencer and the top level
`default_nettype none

package adc_pkg;

  //////////////////////////////
  // widths

  // register value and every host-visible counter
  localparam int data_w     = 24;
  // address byte at the head of a frame
  localparam int addr_w     = 8;
  // address byte plus value
  localparam int frame_bits = 32;
  // set in the address byte -> read only, the write is dropped
  localparam int read_flag_bit = 7;
  // bit counter holds frame_bits and saturates above it
  localparam int bit_cnt_w  = $clog2(frame_bits) + 1;

  //////////////////////////////
  // register map

  localparam logic [addr_w-1:0] reg_led_addr        = 8'd7;
  // latched run-down count, read only
  localparam logic [addr_w-1:0] reg_rundown_addr    = 8'd8;
  localparam logic [addr_w-1:0] reg_phases_addr     = 8'd9;
  // latched up-phase count, read only
  localparam logic [addr_w-1:0] reg_count_up_addr   = 8'd10;
  // write-only action, no storage behind it
  localparam logic [addr_w-1:0] reg_soft_reset_addr = 8'd11;
  // bit 0 is run
  localparam logic [addr_w-1:0] reg_ctrl_addr       = 8'd12;

  //////////////////////////////
  // integrator switch codes

  // {sig, n, p}
  localparam logic [2:0] mux_off = 3'b000;
  localparam logic [2:0] mux_p   = 3'b001;
  localparam logic [2:0] mux_n   = 3'b010;
  // signal switch, or'ed onto p or n during run-up
  localparam logic [2:0] mux_sig = 3'b100;

  //////////////////////////////
  // defaults and timing

  localparam logic [2:0]        led_soft_default   = 3'b101;
  localparam logic [data_w-1:0] phases_default     = 24'd10;
  // interrupt low time before the next conversion
  localparam int                done_hold_clks     = 8;
  localparam int                hold_w             = $clog2(done_hold_clks) + 1;
  // run-up phase length in clk cycles on the board
  localparam int                phase_clks_default = 10000;

endpackage

`default_nettype wire

//--- hw/spi_reg_bank/spi_reg_bank.sv
// serial slave and host register file; oversamples the four serial pins in the clk domain
// frame is an address byte then a 24-bit value, msb first, written when cs_n rises
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        spi_clk,
  input  wire logic                        spi_cs_n,
  input  wire logic                        spi_mosi,
  output logic                             spi_miso,
  input  wire logic [adc_pkg::data_w-1:0]  rundown_count,
  input  wire logic [adc_pkg::data_w-1:0]  count_up,
  output logic [2:0]                       led,
  output logic [adc_pkg::data_w-1:0]       phases,
  output logic                             run
);

  import adc_pkg::*;

  // [0],[1] synchronize, [2] is the previous synchronized value for edge detect
  logic [2:0] sclk_r;
  logic [2:0] cs_r;
  // mosi only needs to line up with sclk_r[1]
  logic [1:0] mosi_r;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_rise;
  logic cs_active;

  logic [frame_bits-1:0] shift_in;
  logic [data_w-1:0]     shift_out;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic                  miso_q;

  // read address without its read flag, as it stands after the 8th rising edge
  logic [addr_w-1:0]     rd_addr;
  logic [data_w-1:0]     rd_val;

  //////////////////////////////
  // pin synchronizers

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      // idle bus: clock low, select high
      sclk_r <= '0;
      cs_r   <= '1;
      mosi_r <= '0;
    end
    else
    begin
      sclk_r <= {sclk_r[1:0], spi_clk};
      cs_r   <= {cs_r[1:0], spi_cs_n};
      mosi_r <= {mosi_r[0], spi_mosi};
    end
  end

  assign sclk_rise = sclk_r[1] & ~sclk_r[2];
  assign sclk_fall = ~sclk_r[1] & sclk_r[2];
  assign cs_rise   = cs_r[1] & ~cs_r[2];
  assign cs_active = ~cs_r[1];

  //////////////////////////////
  // read select

  // top bit forced low so a read-flagged address still selects its register
  assign rd_addr = {1'b0, shift_in[addr_w-3:0], mosi_r[1]};

  always_comb
  begin
    case (rd_addr)
      reg_led_addr:      rd_val = {{(data_w-3){1'b0}}, led};
      reg_rundown_addr:  rd_val = rundown_count;
      reg_phases_addr:   rd_val = phases;
      reg_count_up_addr: rd_val = count_up;
      reg_ctrl_addr:     rd_val = {{(data_w-1){1'b0}}, run};
      default:           rd_val = '0;
    endcase
  end

  //////////////////////////////
  // frame shifter

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      miso_q  <= 1'b0;
    end
    else if (!cs_active)
    begin
      bit_cnt <= '0;
      miso_q  <= 1'b0;
    end
    else if (sclk_rise)
    begin
      // saturate so an overlong frame never looks like exactly 32 bits
      if (bit_cnt != '1)
        bit_cnt <= bit_cnt + 1'b1;
    end
    else if (sclk_fall && bit_cnt >= bit_cnt_w'(addr_w))
    begin
      // 8th falling edge puts bit 23 out, every later one the next bit
      miso_q <= shift_out[data_w-1];
    end
  end

  // payload shift registers
  always_ff @(posedge clk)
  begin
    if (cs_active && sclk_rise)
    begin
      shift_in <= {shift_in[frame_bits-2:0], mosi_r[1]};
      // this rising edge completes the address byte
      if (bit_cnt == bit_cnt_w'(addr_w - 1))
        shift_out <= rd_val;
    end
    else if (cs_active && sclk_fall && bit_cnt >= bit_cnt_w'(addr_w))
    begin
      shift_out <= shift_out << 1;
    end
  end

  assign spi_miso = miso_q;

  //////////////////////////////
  // register writes at the end of a frame

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      led    <= '0;
      phases <= phases_default;
      run    <= 1'b0;
    end
    else if (cs_rise && bit_cnt == bit_cnt_w'(frame_bits))
    begin
      // full address byte compared, a set read flag matches nothing
      case (shift_in[frame_bits-1 -: addr_w])
        reg_led_addr:    led    <= shift_in[2:0];
        reg_phases_addr: phases <= shift_in[data_w-1:0];
        reg_ctrl_addr:   run    <= shift_in[0];
        reg_soft_reset_addr:
        begin
          led <= led_soft_default;
          // conversions stop as well
          run <= 1'b0;
        end
        default:
        begin
          led <= led;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/runup_sequencer/runup_sequencer.sv
// multi-slope conversion sequencer: fixed-length run-up phases steered by the comparator,
// then a timed run-down to the crossing, results latched and int_n pulled low
`timescale 1ns/1ps
`default_nettype none

module runup_sequencer #(
  parameter int phase_clks = adc_pkg::phase_clks_default
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        cmp_out,
  input  wire logic                        run,
  input  wire logic [adc_pkg::data_w-1:0]  phases,
  output logic [2:0]                       mux,
  output logic                             latch_ctl,
  output logic                             int_n,
  output logic [adc_pkg::data_w-1:0]       rundown_count,
  output logic [adc_pkg::data_w-1:0]       count_up
);

  import adc_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_init,
    st_runup,
    st_rundown,
    st_done
  } seq_state_t;

  seq_state_t state;

  // comparator synchronizer, [2] is the value the fsm acts on
  logic [2:0] cmp_r;
  logic       cmp_s;
  logic       cmp_edge;

  logic [data_w-1:0] phase_tmr;
  logic [data_w-1:0] up_cnt;
  logic [data_w-1:0] down_cnt;
  // sampled phases so far
  logic [data_w-1:0] phase_cnt;
  logic [data_w-1:0] rd_cnt;
  logic [hold_w-1:0] hold_tmr;

  logic       phase_end;
  logic [2:0] ref_dir;

  //////////////////////////////
  // comparator sync and edge detect

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cmp_r <= '0;
    else
      cmp_r <= {cmp_r[1:0], cmp_out};
  end

  assign cmp_s    = cmp_r[2];
  // either direction of crossing ends the run-down
  assign cmp_edge = cmp_r[2] ^ cmp_r[1];

  // every sample counts as exactly one up or one down
  assign phase_cnt = up_cnt + down_cnt;
  assign phase_end = (phase_tmr == data_w'(phase_clks - 1));
  // integrator above zero -> drive it back down with n
  assign ref_dir   = cmp_s ? mux_n : mux_p;

  // comparator latch is not used, keep it transparent
  assign latch_ctl = 1'b0;

  //////////////////////////////
  // conversion fsm

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state         <= st_idle;
      mux           <= mux_off;
      int_n         <= 1'b1;
      phase_tmr     <= '0;
      up_cnt        <= '0;
      down_cnt      <= '0;
      rd_cnt        <= '0;
      hold_tmr      <= '0;
      rundown_count <= '0;
      count_up      <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          mux   <= mux_off;
          int_n <= 1'b1;
          if (run)
            state <= st_init;
        end

        st_init:
        begin
          phase_tmr <= '0;
          up_cnt    <= '0;
          down_cnt  <= '0;
          rd_cnt    <= '0;
          // first phase always goes p and is not counted
          mux       <= mux_sig | mux_p;
          state     <= st_runup;
        end

        st_runup:
        begin
          phase_tmr <= phase_tmr + 1'b1;
          if (phase_end)
          begin
            phase_tmr <= '0;
            if (cmp_s)
              up_cnt <= up_cnt + 1'b1;
            else
              down_cnt <= down_cnt + 1'b1;
            // last sample: keep its direction but open the signal switch
            if (phase_cnt + 1'b1 >= phases)
            begin
              mux    <= ref_dir;
              rd_cnt <= '0;
              state  <= st_rundown;
            end
            else
            begin
              mux <= mux_sig | ref_dir;
            end
          end
        end

        st_rundown:
        begin
          rd_cnt <= rd_cnt + 1'b1;
          if (cmp_edge)
          begin
            mux           <= mux_off;
            // count includes this cycle
            rundown_count <= rd_cnt + 1'b1;
            count_up      <= up_cnt;
            int_n         <= 1'b0;
            hold_tmr      <= '0;
            state         <= st_done;
          end
        end

        st_done:
        begin
          hold_tmr <= hold_tmr + 1'b1;
          // int_n has been low done_hold_clks cycles
          if (hold_tmr == hold_w'(done_hold_clks - 1))
          begin
            int_n <= 1'b1;
            state <= run ? st_init : st_idle;
          end
        end

        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/adc_top.sv
// top of the integrating adc controller; wires the board pins to the register bank
// and the run-up sequencer, with no logic of its own
`timescale 1ns/1ps
`default_nettype none

module adc_top #(
  // run-up phase length, shortened in simulation
  parameter int phase_clks = adc_pkg::phase_clks_default
) (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       spi_clk,
  input  wire logic       spi_cs_n,
  input  wire logic       spi_mosi,
  output logic            spi_miso,
  input  wire logic       cmp_out,
  output logic [2:0]      mux,
  output logic            latch_ctl,
  output logic            int_n,
  output logic [2:0]      led
);

  import adc_pkg::*;

  // host control into the sequencer
  logic              run;
  logic [data_w-1:0] phases;
  // latched results back to the host, stable between conversions
  logic [data_w-1:0] rundown_count;
  logic [data_w-1:0] count_up;

  //////////////////////////////
  // serial register bank

  spi_reg_bank regs0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .spi_clk       (spi_clk),
    .spi_cs_n      (spi_cs_n),
    .spi_mosi      (spi_mosi),
    .spi_miso      (spi_miso),
    .rundown_count (rundown_count),
    .count_up      (count_up),
    .led           (led),
    .phases        (phases),
    .run           (run)
  );

  //////////////////////////////
  // conversion sequencer

  runup_sequencer #(
    .phase_clks (phase_clks)
  ) seq0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmp_out       (cmp_out),
    .run           (run),
    .phases        (phases),
    .mux           (mux),
    .latch_ctl     (latch_ctl),
    .int_n         (int_n),
    .rundown_count (rundown_count),
    .count_up      (count_up)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// testbench clock and reset source; 4 ns clock, active-low reset held for the first cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release 1 ns after an edge, like the rest of the stimulus
  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/integrator_model.sv
// behavioral integrator and comparator for the testbench, driven by the dut switch code
// vin is added while the signal switch is closed, ref_step follows the p and n switches
`timescale 1ns/1ps
`default_nettype none

module integrator_model #(
  parameter int ref_step = 64
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               clear,
  input  wire logic [2:0]         mux,
  input  wire logic signed [31:0] vin,
  output logic                    cmp_out
);

  import adc_pkg::*;

  logic signed [31:0] integ;
  logic signed [31:0] ref_part;
  logic signed [31:0] sig_part;

  // p charges up, n discharges, both open is no reference current
  assign ref_part = (mux[1:0] == mux_p[1:0]) ? ref_step :
                    (mux[1:0] == mux_n[1:0]) ? -ref_step : 0;
  assign sig_part = mux[2] ? vin : 0;

  initial integ = '0;

  always @(posedge clk)
  begin
    if (!rst_n || clear)
      integ <= '0;
    else
      integ <= integ + sig_part + ref_part;
  end

  // comparator high while the integral is above zero
  assign cmp_out = (integ > 0);

endmodule

`default_nettype wire

//--- sim/adc_tb.sv
// directed testbench for the integrating adc controller; talks to it over the serial link
// and closes the loop through a behavioral integrator
`timescale 1ns/1ps
`default_nettype none

module adc_tb;

  import adc_pkg::*;

  //////////////////////////////
  // run parameters

  // short run-up phases for simulation
  localparam int phase_clks = 20;
  // serial half-period in clk cycles
  localparam int half_clks  = 8;
  localparam int ref_step   = 64;
  // one frame with select setup and hold
  localparam int frame_clks = (2 * frame_bits + 4) * half_clks;
  localparam int num_frames = 26;
  // phase counts of the four conversion tests
  localparam int conv_budget = (10 + 8 + 16 + 32) * phase_clks * 2 + 4 * 500;
  localparam int watchdog_clks = num_frames * frame_clks + conv_budget;
  localparam logic [31:0] seed = 32'h40b9_e5b8;

  logic              clk;
  logic              rst_n;
  logic              spi_clk;
  logic              spi_cs_n;
  logic              spi_mosi;
  logic              spi_miso;
  logic              cmp_out;
  logic [2:0]        mux;
  logic              latch_ctl;
  logic              int_n;
  logic [2:0]        led;
  logic              model_clear;
  logic              integ_clear;
  logic signed [31:0] vin;
  // rundown count of the last finished conversion test
  logic [data_w-1:0] last_rundown;

  tb_clock clk0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  adc_top #(
    .phase_clks (phase_clks)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi_clk   (spi_clk),
    .spi_cs_n  (spi_cs_n),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso),
    .cmp_out   (cmp_out),
    .mux       (mux),
    .latch_ctl (latch_ctl),
    .int_n     (int_n),
    .led       (led)
  );

  // integrator discharged during the interrupt hold
  // so back-to-back conversions all start from zero
  assign integ_clear = model_clear | ~int_n;

  integrator_model #(
    .ref_step (ref_step)
  ) model0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (integ_clear),
    .mux     (mux),
    .vin     (vin),
    .cmp_out (cmp_out)
  );

  //////////////////////////////
  // helpers

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual)
      report_failure($sformatf("error: %s expected 0x%0h actual 0x%0h",
                               name, expected, actual));
  endtask

  // every wait ends 1 ns after a rising edge where inputs change
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // one frame of nbits msb first with miso sampled just before each rising edge
  task automatic spi_frame(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                           input int nbits, output logic [data_w-1:0] rdata);
    logic [frame_bits-1:0] word;
    word     = {addr, wdata};
    rdata    = '0;
    spi_cs_n = 1'b0;
    wait_clks(half_clks);
    for (int i = 0; i < nbits; i++)
    begin
      spi_mosi = word[frame_bits-1-i];
      wait_clks(half_clks);
      // value bits start after the address byte
      if (i >= addr_w)
        rdata = {rdata[data_w-2:0], spi_miso};
      spi_clk = 1'b1;
      wait_clks(half_clks);
      spi_clk = 1'b0;
    end
    wait_clks(half_clks);
    spi_cs_n = 1'b1;
    // write lands within 6 cycles of the select rising
    wait_clks(half_clks);
  endtask

  task automatic spi_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    logic [data_w-1:0] unused_rd;
    spi_frame(addr, data, frame_bits, unused_rd);
  endtask

  // read flag set so the frame never writes
  task automatic spi_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
    spi_frame(addr | addr_w'(1 << read_flag_bit), '0, frame_bits, data);
  endtask

  function automatic int conv_clks(input int phases);
    return phases * phase_clks * 2 + 500;
  endfunction

  task automatic wait_int_low(input string name, input int max_clks);
    int n;
    n = 0;
    while (int_n !== 1'b0 && n < max_clks)
    begin
      wait_clks(1);
      n++;
    end
    if (int_n !== 1'b0)
      report_failure($sformatf("%s: int_n did not fall within %0d cycles", name, max_clks));
  endtask

  // idle is the only state with mux off and int_n high for more than one cycle
  task automatic wait_idle(input string name, input int max_clks);
    int n;
    int quiet;
    n     = 0;
    quiet = 0;
    while (quiet < 4 && n < max_clks)
    begin
      wait_clks(1);
      n++;
      if (mux == mux_off && int_n == 1'b1)
        quiet++;
      else
        quiet = 0;
    end
    if (quiet < 4)
      report_failure($sformatf("%s: sequencer did not go idle within %0d cycles",
                               name, max_clks));
  endtask

  task automatic clear_model();
    model_clear = 1'b1;
    wait_clks(1);
    model_clear = 1'b0;
  endtask

  task automatic start_conversion(input int phases, input int level);
    vin = level;
    clear_model();
    spi_write(reg_phases_addr, data_w'(phases));
    spi_write(reg_ctrl_addr, 24'd1);
  endtask

  // the current conversion still finishes after run is cleared
  task automatic stop_conversion(input string name, input int phases);
    spi_write(reg_ctrl_addr, 24'd0);
    wait_idle(name, conv_clks(phases));
  endtask

  //////////////////////////////
  // directed tests

  task automatic test_reset_state();
    logic [data_w-1:0] d;
    spi_read(reg_led_addr, d);
    check_eq("reset led register", 32'd0, 32'(d));
    spi_read(reg_phases_addr, d);
    check_eq("reset phases register", 32'(phases_default), 32'(d));
    spi_read(reg_ctrl_addr, d);
    check_eq("reset ctrl register", 32'd0, 32'(d));
    check_eq("reset int_n", 32'd1, 32'(int_n));
    check_eq("reset mux", 32'(mux_off), 32'(mux));
    check_eq("reset latch_ctl", 32'd0, 32'(latch_ctl));
  endtask

  task automatic test_led_register();
    logic [data_w-1:0] val;
    logic [data_w-1:0] d;
    val = data_w'($urandom);
    spi_write(reg_led_addr, val);
    spi_read(reg_led_addr, d);
    check_eq("led write readback", 32'(val[2:0]), 32'(d));
    check_eq("led pins after write", 32'(val[2:0]), 32'(led));
    // same address with the read flag and a full 32 bits
    spi_frame(reg_led_addr | addr_w'(1 << read_flag_bit), ~val, frame_bits, d);
    check_eq("led readout of flagged frame", 32'(val[2:0]), 32'(d));
    check_eq("led pins after flagged frame", 32'(val[2:0]), 32'(led));
    // frame cut short after 20 bits
    spi_frame(reg_led_addr, ~val, 20, d);
    check_eq("led pins after short frame", 32'(val[2:0]), 32'(led));
    spi_read(reg_led_addr, d);
    check_eq("led register after short frame", 32'(val[2:0]), 32'(d));
  endtask

  task automatic test_soft_reset();
    logic [data_w-1:0] d;
    // start from an led value that differs from the soft default in every bit
    spi_write(reg_led_addr, data_w'(~led_soft_default));
    vin = 0;
    clear_model();
    spi_write(reg_ctrl_addr, 24'd1);
    spi_write(reg_soft_reset_addr, 24'd0);
    wait_idle("soft reset", conv_clks(int'(phases_default)));
    spi_read(reg_led_addr, d);
    check_eq("soft reset led register", 32'(led_soft_default), 32'(d));
    check_eq("soft reset led pins", 32'(led_soft_default), 32'(led));
    spi_read(reg_ctrl_addr, d);
    check_eq("soft reset run bit", 32'd0, 32'(d));
  endtask

  task automatic test_zero_input();
    logic [data_w-1:0] d;
    start_conversion(8, 0);
    wait_int_low("zero input", conv_clks(8));
    stop_conversion("zero input", 8);
    spi_read(reg_rundown_addr, d);
    check_eq($sformatf("zero input rundown %0d within 1..%0d", d, phase_clks + 8),
             32'd1, 32'(d > 0 && d <= phase_clks + 8));
  endtask

  task automatic test_charge_balance();
    logic [data_w-1:0] d;
    int diff;
    int err;
    start_conversion(16, ref_step / 4);
    wait_int_low("charge balance", conv_clks(16));
    stop_conversion("charge balance", 16);
    spi_read(reg_count_up_addr, d);
    // up minus down against the input share of all phases
    diff = 2 * int'(d) - 16;
    err  = diff - (16 * (ref_step / 4)) / ref_step;
    check_eq($sformatf("charge balance count_up %0d", d), 32'd1,
             32'(err >= -2 && err <= 2));
    spi_read(reg_rundown_addr, last_rundown);
  endtask

  task automatic test_read_during_conversion();
    logic [data_w-1:0] d;
    // long enough to outlast a whole read frame
    start_conversion(32, 0);
    spi_read(reg_rundown_addr, d);
    check_eq("rundown read during conversion", 32'(last_rundown), 32'(d));
    check_eq("conversion still running after read", 32'd1, 32'(mux != mux_off));
    wait_int_low("read during conversion", conv_clks(32));
    stop_conversion("read during conversion", 32);
  endtask

  //////////////////////////////
  // main sequence and watchdog

  initial
  begin
    logic [31:0] seed_ret;
    spi_clk      = 1'b0;
    spi_cs_n     = 1'b1;
    spi_mosi     = 1'b0;
    model_clear  = 1'b0;
    vin          = 0;
    last_rundown = '0;
    seed_ret     = $urandom(seed);
    wait (rst_n === 1'b1);
    wait_clks(2);
    test_reset_state();
    test_led_register();
    test_soft_reset();
    test_zero_input();
    test_charge_balance();
    test_read_during_conversion();
    $display("Simulation passed");
    $finish;
  end

  initial
  begin
    repeat (watchdog_clks) @(posedge clk);
    report_failure($sformatf("watchdog timeout: tests still running after %0d cycles",
                             watchdog_clks));
  end

endmodule

`default_nettype wire

//--- project.f
common/adc_pkg.sv
hw/spi_reg_bank/spi_reg_bank.sv
hw/runup_sequencer/runup_sequencer.sv
hw/adc_top.sv
sim/tb_clock.sv
sim/integrator_model.sv
sim/adc_tb.sv

//--- Makefile
# Verilator flow for the integrating ADC controller
# override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= project.f
TB_TOP     ?= adc_tb
RTL_TOP    ?= adc_top
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing

# RTL sources are the file list without the testbench folder
RTL_FILES := $(shell grep -v -e '^sim/' -e '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_FILES)

# exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
